//--- Makefile
SRCS := $(shell cat dcache.f)

.PHONY: all run clean

all: run

obj_dir/VdcacheTb: dcache.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module dcacheTb \
	  -f dcache.f --Mdir obj_dir -o VdcacheTb

run: obj_dir/VdcacheTb
	obj_dir/VdcacheTb | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dcache.f
logic/dcachePkg.sv
logic/cacheWay.sv
logic/refillBuffer.sv
logic/wayMerge.sv
logic/dcacheCtrl.sv
logic/dcacheTop.sv
sim/memModel.sv
sim/dcacheTb.sv

//--- logic/cacheWay.sv
`default_nettype none

module cacheWay (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [dcachePkg::IndexWidth-1:0] index_i,
  input  logic [dcachePkg::TagWidth-1:0]   tag_i,
  input  logic                             we_i,
  input  dcachePkg::wayWrite_t             wr_i,
  output dcachePkg::wayStatus_t            status_o
);
  import dcachePkg::*;

  logic [TagWidth-1:0] tagArray [NumSets];
  lineData_t           lineArray [NumSets];
  logic [NumSets-1:0]  validBits;
  logic [NumSets-1:0]  dirtyBits;
  logic                wayHit;
  lineData_t           bitMask;
  lineData_t           mergedLine;

  // lookup is combinational on the latched index
  assign wayHit = validBits[index_i] && (tagArray[index_i] == tag_i);

  always_comb begin
    status_o.hit = wayHit;
    status_o.valid = validBits[index_i];
    status_o.dirty = dirtyBits[index_i];
    status_o.tag = tagArray[index_i];
    status_o.line = lineArray[index_i];
  end

  // byte enables widened to bit enables
  always_comb begin
    for (int b = 0; b < LineWidth / 8; b++) begin
      bitMask[b*8 +: 8] = {8{wr_i.byteMask[b]}};
    end
  end

  assign mergedLine = (lineArray[wr_i.index] & ~bitMask) | (wr_i.line & bitMask);

  always_ff @(posedge clk) begin
    if (we_i && wr_i.fill) begin
      tagArray[wr_i.index] <= tag_i;
      lineArray[wr_i.index] <= wr_i.line;
    end else if (we_i && wr_i.store && wayHit) begin
      lineArray[wr_i.index] <= mergedLine;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (we_i && wr_i.fill) begin
      validBits[wr_i.index] <= 1'b1;
      dirtyBits[wr_i.index] <= 1'b0;
    end else if (we_i && wr_i.store && wayHit) begin
      dirtyBits[wr_i.index] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/dcacheCtrl.sv
`default_nettype none

module dcacheCtrl (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  reqValid_i,
  input  dcachePkg::cpuReq_t                    req_i,
  input  logic                                  hit_i,
  input  logic                                  victimDirty_i,
  input  dcachePkg::lineData_t                  refillLine_i,
  input  logic                                  rdReady_i,
  input  logic                                  rdDataValid_i,
  input  logic                                  rdLast_i,
  input  logic                                  wrReady_i,
  input  dcachePkg::memWrReq_t                  victimReq_i,
  output logic                                  reqReady_o,
  output logic                                  respValid_o,
  output dcachePkg::addr_u                      reqAddr_o,
  output logic [$clog2(dcachePkg::NumWays)-1:0] victimWay_o,
  output dcachePkg::wayWrite_t                  wayWr_o,
  output logic [dcachePkg::NumWays-1:0]         wayWe_o,
  output logic                                  refillClear_o,
  output logic                                  rdReqValid_o,
  output dcachePkg::addr_u                      rdAddr_o,
  output logic                                  wrReqValid_o,
  output dcachePkg::memWrReq_t                  wrReq_o
);
  import dcachePkg::*;

  ctrlState_t state;
  ctrlState_t nextState;
  cpuReq_t    reqLatch;
  logic [$clog2(NumWays)-1:0] replBit;
  logic       uncachedStore;
  logic       storeHit;
  wordData_t  storeWord;
  byteMask_t  storeMask;
  memWrReq_t  uncReq;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  // request payload, taken only on acceptance
  always_ff @(posedge clk) begin
    if (reqValid_i && reqReady_o) begin
      reqLatch <= req_i;
    end
  end

  // flips once per miss, after the victim line is replaced
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      replBit <= '0;
    end else if (state == Fill) begin
      replBit <= replBit + 1'b1;
    end
  end

  assign uncachedStore = reqLatch.write && (reqLatch.addr.region.region != CachedRegion);
  assign storeHit = (state == Lookup) && reqLatch.write && !uncachedStore && hit_i;

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (reqValid_i) nextState = Lookup;
      end
      Lookup: begin
        if (uncachedStore) begin
          nextState = Uncached;
        end else if (hit_i) begin
          nextState = Idle;
        end else if (victimDirty_i) begin
          nextState = WriteBack;
        end else begin
          nextState = RefillReq;
        end
      end
      WriteBack: begin
        if (wrReady_i) nextState = RefillReq;
      end
      RefillReq: begin
        if (rdReady_i) nextState = Refill;
      end
      Refill: begin
        if (rdDataValid_i && rdLast_i) nextState = Fill;
      end
      Fill: begin
        nextState = Lookup;
      end
      Uncached: begin
        if (wrReady_i) nextState = Idle;
      end
      default: begin
        nextState = Idle;
      end
    endcase
  end

  assign reqReady_o = (state == Idle);
  assign respValid_o = ((state == Lookup) && hit_i && !uncachedStore) ||
                       ((state == Uncached) && wrReady_i);
  assign reqAddr_o = reqLatch.addr;
  assign victimWay_o = replBit;

  // right-aligned store word moved to its byte lane
  assign storeWord = reqLatch.data << {reqLatch.addr.line.byteOff, 3'b000};
  assign storeMask = reqLatch.mask << reqLatch.addr.line.byteOff;

  always_comb begin
    wayWr_o = '0;
    wayWr_o.index = reqLatch.addr.line.index;
    wayWr_o.fill = (state == Fill);
    wayWr_o.store = storeHit;
    if (state == Fill) begin
      wayWr_o.line = refillLine_i;
      wayWr_o.byteMask = '1;
    end else begin
      wayWr_o.line = {BeatsPerLine{storeWord}};
      wayWr_o.byteMask[reqLatch.addr.line.word*8 +: 8] = storeMask;
    end
  end

  // a store hit enables every way, only the hitting way takes it
  always_comb begin
    wayWe_o = '0;
    if (state == Fill) begin
      wayWe_o[replBit] = 1'b1;
    end else if (storeHit) begin
      wayWe_o = '1;
    end
  end

  assign refillClear_o = (state == RefillReq);
  assign rdReqValid_o = (state == RefillReq);
  assign rdAddr_o = {reqLatch.addr.line.tag, reqLatch.addr.line.index, {OffsetWidth{1'b0}}};

  always_comb begin
    uncReq = '0;
    uncReq.addr = reqLatch.addr;
    uncReq.addr[2:0] = 3'b000;
    uncReq.data[XLen-1:0] = storeWord;
    uncReq.mask = storeMask;
    uncReq.single = 1'b1;
  end

  assign wrReqValid_o = (state == WriteBack) || (state == Uncached);
  assign wrReq_o = (state == Uncached) ? uncReq : victimReq_i;

endmodule

`default_nettype wire

//--- logic/dcachePkg.sv
`default_nettype none

package dcachePkg;

  localparam int AddrWidth = 32;
  localparam int XLen = 64;
  localparam int LineWidth = 256;
  localparam int BeatsPerLine = 4;
  localparam int NumWays = 2;
  localparam int NumSets = 64;
  localparam int OffsetWidth = 5;
  localparam int IndexWidth = 6;
  localparam int TagWidth = 21;
  localparam logic [3:0] CachedRegion = 4'b1000;

  typedef logic [LineWidth-1:0] lineData_t;
  typedef logic [XLen-1:0] wordData_t;
  typedef logic [7:0] byteMask_t;

  // the same address word, seen as cache fields or as memory region
  typedef union packed {
    struct packed {
      logic [TagWidth-1:0]   tag;
      logic [IndexWidth-1:0] index;
      logic [1:0]            word;
      logic [2:0]            byteOff;
    } line;
    struct packed {
      logic [3:0]  region;
      logic [27:0] rest;
    } region;
  } addr_u;

  typedef struct packed {
    logic      write;
    addr_u     addr;
    wordData_t data;
    byteMask_t mask;
  } cpuReq_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    lineData_t            data;
    byteMask_t            mask;
    logic                 single;
  } memWrReq_t;

  typedef struct packed {
    logic                hit;
    logic                valid;
    logic                dirty;
    logic [TagWidth-1:0] tag;
    lineData_t           line;
  } wayStatus_t;

  typedef struct packed {
    logic [IndexWidth-1:0]  index;
    logic                   fill;
    logic                   store;
    lineData_t              line;
    logic [LineWidth/8-1:0] byteMask;
  } wayWrite_t;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    RefillReq,
    Refill,
    Fill,
    Uncached
  } ctrlState_t;

endpackage

`default_nettype wire

//--- logic/dcacheTop.sv
`default_nettype none

module dcacheTop (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 reqValid_i,
  input  dcachePkg::cpuReq_t   req_i,
  output logic                 reqReady_o,
  output logic                 respValid_o,
  output dcachePkg::wordData_t rdData_o,
  output logic                 rdReqValid_o,
  output dcachePkg::addr_u     rdAddr_o,
  input  logic                 rdReady_i,
  input  logic                 rdDataValid_i,
  input  dcachePkg::wordData_t rdData_i,
  input  logic                 rdLast_i,
  output logic                 wrReqValid_o,
  output dcachePkg::memWrReq_t wrReq_o,
  input  logic                 wrReady_i
);
  import dcachePkg::*;

  addr_u                      reqAddr;
  logic [$clog2(NumWays)-1:0] victimWay;
  wayWrite_t                  wayWr;
  logic [NumWays-1:0]         wayWe;
  wayStatus_t                 wayStatus [NumWays];
  logic                       refillClear;
  lineData_t                  refillLine;
  logic                       hit;
  logic                       victimDirty;
  memWrReq_t                  victimReq;

  dcacheCtrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .req_i         (req_i),
    .hit_i         (hit),
    .victimDirty_i (victimDirty),
    .refillLine_i  (refillLine),
    .rdReady_i     (rdReady_i),
    .rdDataValid_i (rdDataValid_i),
    .rdLast_i      (rdLast_i),
    .wrReady_i     (wrReady_i),
    .victimReq_i   (victimReq),
    .reqReady_o    (reqReady_o),
    .respValid_o   (respValid_o),
    .reqAddr_o     (reqAddr),
    .victimWay_o   (victimWay),
    .wayWr_o       (wayWr),
    .wayWe_o       (wayWe),
    .refillClear_o (refillClear),
    .rdReqValid_o  (rdReqValid_o),
    .rdAddr_o      (rdAddr_o),
    .wrReqValid_o  (wrReqValid_o),
    .wrReq_o       (wrReq_o)
  );

  // identical ways, told apart only by their write enable
  for (genvar w = 0; w < NumWays; w++) begin : g_way
    cacheWay u_way (
      .clk      (clk),
      .rst_n    (rst_n),
      .index_i  (reqAddr.line.index),
      .tag_i    (reqAddr.line.tag),
      .we_i     (wayWe[w]),
      .wr_i     (wayWr),
      .status_o (wayStatus[w])
    );
  end

  refillBuffer u_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (refillClear),
    .beatValid_i (rdDataValid_i),
    .beat_i      (rdData_i),
    .line_o      (refillLine)
  );

  wayMerge u_merge (
    .status_i      (wayStatus),
    .addr_i        (reqAddr),
    .victimWay_i   (victimWay),
    .hit_o         (hit),
    .rdData_o      (rdData_o),
    .victimDirty_o (victimDirty),
    .victimReq_o   (victimReq)
  );

endmodule

`default_nettype wire

//--- logic/refillBuffer.sv
`default_nettype none

module refillBuffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clear_i,
  input  logic                 beatValid_i,
  input  dcachePkg::wordData_t beat_i,
  output dcachePkg::lineData_t line_o
);
  import dcachePkg::*;

  logic [$clog2(BeatsPerLine)-1:0] beatCnt;
  lineData_t                       lineReg;

  // beat position, restarted before every refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (clear_i) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // beats come in ascending word order
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineReg[beatCnt*XLen +: XLen] <= beat_i;
    end
  end

  assign line_o = lineReg;

endmodule

`default_nettype wire

//--- logic/wayMerge.sv
`default_nettype none

module wayMerge (
  input  dcachePkg::wayStatus_t                 status_i [dcachePkg::NumWays],
  input  dcachePkg::addr_u                      addr_i,
  input  logic [$clog2(dcachePkg::NumWays)-1:0] victimWay_i,
  output logic                                  hit_o,
  output dcachePkg::wordData_t                  rdData_o,
  output logic                                  victimDirty_o,
  output dcachePkg::memWrReq_t                  victimReq_o
);
  import dcachePkg::*;

  wayStatus_t victim;

  // at most one way hits, so the words can be ORed
  always_comb begin
    hit_o = 1'b0;
    rdData_o = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (status_i[w].hit) begin
        hit_o = 1'b1;
        rdData_o = rdData_o | status_i[w].line[addr_i.line.word*XLen +: XLen];
      end
    end
  end

  assign victim = status_i[victimWay_i];

  // only a valid line can need a write-back
  assign victimDirty_o = victim.valid && victim.dirty;

  // whole-line write at the victim's own address
  always_comb begin
    victimReq_o.addr = {victim.tag, addr_i.line.index, {OffsetWidth{1'b0}}};
    victimReq_o.data = victim.line;
    victimReq_o.mask = '1;
    victimReq_o.single = 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/dcacheTb.sv
`default_nettype none

module dcacheTb;
  timeunit 1ns;
  timeprecision 1ps;
  import dcachePkg::*;

  localparam int RandomOps = 500;
  localparam int DirectedOps = 11;
  localparam int CycleLimit = 400 * (RandomOps + DirectedOps) + 2000;

  typedef struct packed {
    logic      isLoad;
    logic      hitExpected;
    wordData_t data;
    int        acceptCycle;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        reqValid_i;
  cpuReq_t     req_i;
  logic        reqReady_o;
  logic        respValid_o;
  wordData_t   rdData_o;
  logic        rdReqValid_o;
  addr_u       rdAddr_o;
  logic        rdReady_i;
  logic        rdDataValid_i;
  wordData_t   rdData_i;
  logic        rdLast_i;
  logic        wrReqValid_o;
  memWrReq_t   wrReq_o;
  logic        wrReady_i;
  int          rdCount;
  logic [31:0] rdLastAddr;
  int          wrCount;
  memWrReq_t   wrLast;

  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;
  int          issued = 0;
  int          responded = 0;
  expect_t     expQ[$];
  wordData_t   shadow [logic [31:0]];

  dcacheTop dut (.*);

  memModel mem (
    .clk           (clk),
    .rdReqValid_i  (rdReqValid_o),
    .rdAddr_i      (rdAddr_o),
    .rdReady_o     (rdReady_i),
    .rdDataValid_o (rdDataValid_i),
    .rdData_o      (rdData_i),
    .rdLast_o      (rdLast_i),
    .wrReqValid_i  (wrReqValid_o),
    .wrReq_i       (wrReq_o),
    .wrReady_o     (wrReady_i),
    .rdCount_o     (rdCount),
    .rdLastAddr_o  (rdLastAddr),
    .wrCount_o     (wrCount),
    .wrLast_o      (wrLast)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic wordData_t patternWord(input logic [31:0] dwAddr);
    return {dwAddr, ~dwAddr} ^ 64'hc3a5_5a3c_0ff0_9669;
  endfunction

  // expected load word from the shadow copy of memory
  function automatic wordData_t refRead(input logic [31:0] addr);
    logic [31:0] dw;
    dw = {addr[31:3], 3'b000};
    if (shadow.exists(dw)) begin
      return shadow[dw];
    end
    return patternWord(dw);
  endfunction

  // data and mask move up by the byte offset and lose what overflows
  function automatic void shadowStore(input cpuReq_t r);
    logic [31:0] a;
    wordData_t   word;
    wordData_t   data;
    byteMask_t   mask;
    a = r.addr;
    word = refRead(a);
    data = r.data << (8 * r.addr.line.byteOff);
    mask = r.mask << r.addr.line.byteOff;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) word[b*8 +: 8] = data[b*8 +: 8];
    end
    shadow[{a[31:3], 3'b000}] = word;
  endfunction

  function automatic memWrReq_t uncachedWrite(input cpuReq_t r);
    memWrReq_t   e;
    logic [31:0] a;
    a = r.addr;
    e = '0;
    e.addr = {a[31:3], 3'b000};
    e.data[XLen-1:0] = r.data << (8 * r.addr.line.byteOff);
    e.mask = r.mask << r.addr.line.byteOff;
    e.single = 1'b1;
    return e;
  endfunction

  // write-back of a whole line as the shadow sees it now
  function automatic memWrReq_t lineWrite(input logic [31:0] addr);
    memWrReq_t e;
    e.addr = {addr[31:5], 5'b00000};
    for (int b = 0; b < BeatsPerLine; b++) begin
      e.data[b*XLen +: XLen] = refRead(e.addr + 32'(b * 8));
    end
    e.mask = '1;
    e.single = 1'b0;
    return e;
  endfunction

  function automatic cpuReq_t makeReq(input logic write, input logic [31:0] addr,
                                      input wordData_t data, input byteMask_t mask);
    cpuReq_t r;
    r.write = write;
    r.addr = addr;
    r.data = data;
    r.mask = mask;
    return r;
  endfunction

  task automatic checkRead(input wordData_t got, input wordData_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: load returned %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkWrite(input memWrReq_t got, input memWrReq_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: write addr %h mask %h single %b, expected %h %h %b",
               $time, got.addr, got.mask, got.single, exp.addr, exp.mask, exp.single);
      $display("error at %0t: write data %h, expected %h", $time, got.data, exp.data);
    end
  endtask

  task automatic checkIdle();
    checks++;
    if (reqReady_o !== 1'b1 || respValid_o !== 1'b0 || rdReqValid_o !== 1'b0 ||
        wrReqValid_o !== 1'b0) begin
      errors++;
      $display("error at %0t: ready %b resp %b rdReq %b wrReq %b, expected idle levels",
               $time, reqReady_o, respValid_o, rdReqValid_o, wrReqValid_o);
    end
  endtask

  task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one request at a time and back once it has been answered
  task automatic issue(input cpuReq_t r, input logic hitExpected);
    expect_t e;
    while (!reqReady_o) @(negedge clk);
    e.isLoad = !r.write;
    e.hitExpected = hitExpected;
    e.data = r.write ? '0 : refRead(r.addr);
    e.acceptCycle = cycle;
    expQ.push_back(e);
    if (r.write) shadowStore(r);
    req_i = r;
    reqValid_i = 1'b1;
    issued++;
    @(negedge clk);
    reqValid_i = 1'b0;
    while (responded < issued) @(negedge clk);
  endtask

  task automatic loadWord(input logic [31:0] addr, input logic hitExpected);
    issue(makeReq(1'b0, addr, '0, '0), hitExpected);
  endtask

  task automatic storeBytes(input logic [31:0] addr, input wordData_t data,
                            input byteMask_t mask, input logic hitExpected);
    issue(makeReq(1'b1, addr, data, mask), hitExpected);
  endtask

  // responses sampled just before the rising edge
  always @(posedge clk) begin
    expect_t e;
    if (rst_n && respValid_o) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("a response arrived while no request was outstanding");
      end else begin
        e = expQ.pop_front();
        if (e.isLoad) checkRead(rdData_o, e.data);
        if (e.hitExpected && cycle != e.acceptCycle + 1) begin
          errors++;
          $display("error at %0t: hit answered %0d cycles after acceptance",
                   $time, cycle - e.acceptCycle);
        end
        responded++;
      end
    end
    cycle++;
    if (cycle > CycleLimit) begin
      $display("the run timed out after %0d cycles, %0d of %0d requests answered",
               cycle, responded, issued);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] addr;
    cpuReq_t     r;
    int          rdBefore;
    int          wrBefore;
    void'($urandom(32'hd68801ab));
    rst_n = 1'b0;
    reqValid_i = 1'b0;
    req_i = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    checkIdle();

    // miss with refill and then a hit in the same line
    rdBefore = rdCount;
    loadWord(32'h8000_0068, 1'b0);
    compareValue(rdCount, rdBefore + 1, "refill count");
    compareValue(rdLastAddr, 32'h8000_0060, "refill address");
    loadWord(32'h8000_0078, 1'b1);
    compareValue(rdCount, rdBefore + 1, "refill count after hit");

    // partial mask at byte offset 3
    storeBytes(32'h8000_0073, 64'h0000_00a1_b2c3_d4e5, 8'h1d, 1'b1);
    loadWord(32'h8000_0070, 1'b1);
    loadWord(32'h8000_0078, 1'b1);
    loadWord(32'h8000_0068, 1'b1);

    // three lines on index 10 force out the first one
    storeBytes(32'h8001_0148, 64'h1111_2222_3333_4444, 8'hff, 1'b0);
    storeBytes(32'h8002_0150, 64'h5555_6666_7777_8888, 8'h0f, 1'b0);
    wrBefore = wrCount;
    storeBytes(32'h8003_0140, 64'h9999_aaaa_bbbb_cccc, 8'hf0, 1'b0);
    compareValue(wrCount, wrBefore + 1, "write-back count");
    checkWrite(wrLast, lineWrite(32'h8001_0140));
    wrBefore = wrCount;
    loadWord(32'h8001_0148, 1'b0);
    compareValue(wrCount, wrBefore + 1, "write-back count on re-read");
    checkWrite(wrLast, lineWrite(32'h8002_0140));

    // store outside the cached region
    rdBefore = rdCount;
    wrBefore = wrCount;
    r = makeReq(1'b1, 32'h2000_1235, 64'h0000_0000_00c0_ffee, 8'h07);
    issue(r, 1'b0);
    compareValue(wrCount, wrBefore + 1, "uncached write count");
    compareValue(rdCount, rdBefore, "read count on uncached store");
    checkWrite(wrLast, uncachedWrite(r));
    checkIdle();

    // four indices with four tags each
    for (int i = 0; i < RandomOps; i++) begin
      addr = 32'h8000_0000 | ($urandom_range(3, 0) << 12) |
             ((20 + $urandom_range(3, 0)) << 5) | $urandom_range(31, 0);
      if ($urandom_range(1, 0) == 1) begin
        storeBytes(addr, {$urandom(), $urandom()}, 8'($urandom()), 1'b0);
      end else begin
        loadWord(addr, 1'b0);
      end
    end

    $display("checks %0d, errors %0d, requests %0d", checks, errors, issued);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/memModel.sv
`default_nettype none

module memModel (
  input  logic                 clk,
  input  logic                 rdReqValid_i,
  input  dcachePkg::addr_u     rdAddr_i,
  output logic                 rdReady_o,
  output logic                 rdDataValid_o,
  output dcachePkg::wordData_t rdData_o,
  output logic                 rdLast_o,
  input  logic                 wrReqValid_i,
  input  dcachePkg::memWrReq_t wrReq_i,
  output logic                 wrReady_o,
  output int                   rdCount_o,
  output logic [31:0]          rdLastAddr_o,
  output int                   wrCount_o,
  output dcachePkg::memWrReq_t wrLast_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import dcachePkg::*;

  // sparse backing store, keyed by doubleword address
  wordData_t store [logic [31:0]];

  function automatic wordData_t patternWord(input logic [31:0] dwAddr);
    return {dwAddr, ~dwAddr} ^ 64'hc3a5_5a3c_0ff0_9669;
  endfunction

  function automatic wordData_t readWord(input logic [31:0] dwAddr);
    if (store.exists(dwAddr)) begin
      return store[dwAddr];
    end
    return patternWord(dwAddr);
  endfunction

  function automatic void writeWord(input logic [31:0] dwAddr, input wordData_t data,
                                    input byteMask_t mask);
    wordData_t word;
    word = readWord(dwAddr);
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) word[b*8 +: 8] = data[b*8 +: 8];
    end
    store[dwAddr] = word;
  endfunction

  // read grant after a random delay, then four beats with gaps
  initial begin
    logic [31:0] lineAddr;
    rdReady_o = 1'b0;
    rdDataValid_o = 1'b0;
    rdData_o = '0;
    rdLast_o = 1'b0;
    rdCount_o = 0;
    rdLastAddr_o = '0;
    forever begin
      @(negedge clk);
      if (rdReqValid_i) begin
        lineAddr = rdAddr_i;
        repeat ($urandom_range(3, 0)) @(negedge clk);
        rdReady_o = 1'b1;
        rdCount_o++;
        rdLastAddr_o = lineAddr;
        @(negedge clk);
        rdReady_o = 1'b0;
        for (int b = 0; b < BeatsPerLine; b++) begin
          repeat ($urandom_range(2, 0)) @(negedge clk);
          rdDataValid_o = 1'b1;
          rdData_o = readWord(lineAddr + 32'(b * 8));
          rdLast_o = (b == BeatsPerLine - 1);
          @(negedge clk);
          rdDataValid_o = 1'b0;
          rdLast_o = 1'b0;
        end
      end
    end
  end

  // write acceptance, single doubleword or whole line
  initial begin
    memWrReq_t req;
    wrReady_o = 1'b0;
    wrCount_o = 0;
    wrLast_o = '0;
    forever begin
      @(negedge clk);
      if (wrReqValid_i) begin
        repeat ($urandom_range(3, 0)) @(negedge clk);
        req = wrReq_i;
        wrReady_o = 1'b1;
        if (req.single) begin
          writeWord(req.addr, req.data[XLen-1:0], req.mask);
        end else begin
          for (int b = 0; b < BeatsPerLine; b++) begin
            writeWord(req.addr + 32'(b * 8), req.data[b*XLen +: XLen], 8'hff);
          end
        end
        wrCount_o++;
        wrLast_o = req;
        @(negedge clk);
        wrReady_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
